// File: include/sdram_defines.svh
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

// Device geometry.
`define SDRAM_COL_W 9
`define SDRAM_ROW_W 13
`define SDRAM_BANK_W 2

// Timing in controller clock cycles.
`define SDRAM_CAS_LAT 2
`define SDRAM_TRCD 2
`define SDRAM_TRP 2
`define SDRAM_TRFC 7
`define SDRAM_INIT_CYCLES 200
`define SDRAM_REFRESH_CYCLES 780

// One receiver entry per link.
`define SDRAM_CREDITS 1

`endif

// File: rtl/sdram_pkg.sv
`default_nettype none
`include "sdram_defines.svh"

package sdram_pkg;

  typedef logic [31:0] axi_addr_t;
  typedef logic [3:0]  axi_id_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // Column, row, bank from the low bits up.
  typedef logic [`SDRAM_COL_W+`SDRAM_ROW_W+`SDRAM_BANK_W-1:0] word_addr_t;

  typedef logic [`SDRAM_ROW_W-1:0] sdram_a_t;

  typedef enum logic [3:0] {
    INIT_WAIT,
    INIT_PRECHARGE,
    INIT_REFRESH,
    INIT_MODE,
    IDLE,
    ACTIVATE,
    ACCESS,
    READ_WAIT,
    PRECHARGE_WAIT,
    REFRESH_WAIT
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/mem_req_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_req_if
  import sdram_pkg::*;
();

  logic       valid;
  logic       write;
  word_addr_t addr;
  data_t      wdata;
  strb_t      strb;

  // One-cycle pulse per completed request, rdata valid alongside.
  logic       credit;
  data_t      rdata;

  modport requester (
    output valid, write, addr, wdata, strb,
    input  credit, rdata
  );

  modport server (
    input  valid, write, addr, wdata, strb,
    output credit, rdata
  );

endinterface

`default_nettype wire

// File: rtl/axi_write_port.sv
`timescale 1ns/1ns
`default_nettype none
`include "sdram_defines.svh"

module axi_write_port
  import sdram_pkg::*;
(
  input  wire            clk_i,
  input  wire            rst_n_i,
  input  wire            awvalid_i,
  input  wire axi_addr_t awaddr_i,
  input  wire axi_id_t   awid_i,
  output logic           awready_o,
  input  wire            wvalid_i,
  input  wire data_t     wdata_i,
  input  wire strb_t     wstrb_i,
  output logic           wready_o,
  input  wire            bready_i,
  output logic           bvalid_o,
  output logic [1:0]     bresp_o,
  output axi_id_t        bid_o,
  mem_req_if.requester   req
);

  logic [1:0] credits_q;
  logic       busy_q;
  logic       req_valid_q;
  logic       bvalid_q;
  logic       accept;
  word_addr_t addr_q;
  data_t      wdata_q;
  strb_t      strb_q;
  axi_id_t    id_q;

  // AW and W are taken together, one transaction at a time.
  assign accept    = awvalid_i && wvalid_i && !busy_q && (credits_q != '0);
  assign awready_o = accept;
  assign wready_o  = accept;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits_q   <= 2'(`SDRAM_CREDITS);
      busy_q      <= 1'b0;
      req_valid_q <= 1'b0;
      bvalid_q    <= 1'b0;
    end else begin
      req_valid_q <= accept;
      credits_q   <= credits_q + 2'(req.credit) - 2'(req_valid_q);
      if (accept) begin
        busy_q <= 1'b1;
      end else if (bvalid_q && bready_i) begin
        busy_q <= 1'b0;
      end
      if (req.credit) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= awaddr_i[$bits(word_addr_t)+1:2];
      wdata_q <= wdata_i;
      strb_q  <= wstrb_i;
      id_q    <= awid_i;
    end
  end

  assign req.valid = req_valid_q;
  assign req.write = 1'b1;
  assign req.addr  = addr_q;
  assign req.wdata = wdata_q;
  assign req.strb  = strb_q;

  assign bvalid_o = bvalid_q;
  assign bresp_o  = 2'b00;
  assign bid_o    = id_q;

endmodule

`default_nettype wire

// File: rtl/axi_read_port.sv
`timescale 1ns/1ns
`default_nettype none
`include "sdram_defines.svh"

module axi_read_port
  import sdram_pkg::*;
(
  input  wire            clk_i,
  input  wire            rst_n_i,
  input  wire            arvalid_i,
  input  wire axi_addr_t araddr_i,
  input  wire axi_id_t   arid_i,
  output logic           arready_o,
  input  wire            rready_i,
  output logic           rvalid_o,
  output logic [1:0]     rresp_o,
  output data_t          rdata_o,
  output logic           rlast_o,
  output axi_id_t        rid_o,
  mem_req_if.requester   req
);

  logic [1:0] credits_q;
  logic       busy_q;
  logic       req_valid_q;
  logic       rvalid_q;
  logic       accept;
  word_addr_t addr_q;
  axi_id_t    id_q;
  data_t      rdata_q;

  assign accept    = arvalid_i && !busy_q && (credits_q != '0);
  assign arready_o = accept;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits_q   <= 2'(`SDRAM_CREDITS);
      busy_q      <= 1'b0;
      req_valid_q <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      req_valid_q <= accept;
      credits_q   <= credits_q + 2'(req.credit) - 2'(req_valid_q);
      if (accept) begin
        busy_q <= 1'b1;
      end else if (rvalid_q && rready_i) begin
        busy_q <= 1'b0;
      end
      if (req.credit) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= araddr_i[$bits(word_addr_t)+1:2];
      id_q   <= arid_i;
    end
    // Held until rready.
    if (req.credit) begin
      rdata_q <= req.rdata;
    end
  end

  assign req.valid = req_valid_q;
  assign req.write = 1'b0;
  assign req.addr  = addr_q;
  assign req.wdata = '0;
  assign req.strb  = '0;

  assign rvalid_o = rvalid_q;
  assign rresp_o  = 2'b00;
  assign rdata_o  = rdata_q;
  assign rlast_o  = 1'b1;
  assign rid_o    = id_q;

endmodule

`default_nettype wire

// File: rtl/req_arbiter.sv
`timescale 1ns/1ns
`default_nettype none
`include "sdram_defines.svh"

module req_arbiter
  import sdram_pkg::*;
(
  input  wire          clk_i,
  input  wire          rst_n_i,
  mem_req_if.server    wr_req,
  mem_req_if.server    rd_req,
  mem_req_if.requester mem
);

  logic [1:0] credits_q;
  logic       wr_pend_q;
  logic       rd_pend_q;
  logic       rr_q;
  logic       owner_q;
  logic       mem_valid_q;
  logic       grant;
  logic       grant_rd;
  word_addr_t wr_addr_q;
  data_t      wr_wdata_q;
  strb_t      wr_strb_q;
  word_addr_t rd_addr_q;
  word_addr_t mem_addr_q;
  data_t      mem_wdata_q;
  strb_t      mem_strb_q;

  // rr_q high gives the read slot priority.
  assign grant    = (credits_q != '0) && (wr_pend_q || rd_pend_q);
  assign grant_rd = rd_pend_q && (!wr_pend_q || rr_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits_q   <= 2'(`SDRAM_CREDITS);
      wr_pend_q   <= 1'b0;
      rd_pend_q   <= 1'b0;
      rr_q        <= 1'b0;
      owner_q     <= 1'b0;
      mem_valid_q <= 1'b0;
    end else begin
      mem_valid_q <= grant;
      credits_q   <= credits_q + 2'(mem.credit) - 2'(grant);
      if (grant) begin
        owner_q <= grant_rd;
        rr_q    <= !grant_rd;
      end
      if (wr_req.valid) begin
        wr_pend_q <= 1'b1;
      end else if (wr_req.credit) begin
        wr_pend_q <= 1'b0;
      end
      if (rd_req.valid) begin
        rd_pend_q <= 1'b1;
      end else if (rd_req.credit) begin
        rd_pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_req.valid) begin
      wr_addr_q  <= wr_req.addr;
      wr_wdata_q <= wr_req.wdata;
      wr_strb_q  <= wr_req.strb;
    end
    if (rd_req.valid) begin
      rd_addr_q <= rd_req.addr;
    end
    if (grant) begin
      mem_addr_q  <= grant_rd ? rd_addr_q : wr_addr_q;
      mem_wdata_q <= wr_wdata_q;
      mem_strb_q  <= wr_strb_q;
    end
  end

  assign mem.valid = mem_valid_q;
  assign mem.write = !owner_q;
  assign mem.addr  = mem_addr_q;
  assign mem.wdata = mem_wdata_q;
  assign mem.strb  = mem_strb_q;

  // Completion goes back to whichever port owns the access.
  assign wr_req.credit = mem.credit && !owner_q;
  assign rd_req.credit = mem.credit && owner_q;
  assign wr_req.rdata  = mem.rdata;
  assign rd_req.rdata  = mem.rdata;

endmodule

`default_nettype wire

// File: rtl/sdram_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "sdram_defines.svh"

module sdram_ctrl
  import sdram_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_n_i,
  mem_req_if.server                req,
  output logic                     sdram_clk_o,
  output logic                     sdram_cke_o,
  output logic                     sdram_cs_o,
  output logic                     sdram_ras_o,
  output logic                     sdram_cas_o,
  output logic                     sdram_we_o,
  output sdram_a_t                 sdram_a_o,
  output logic [`SDRAM_BANK_W-1:0] sdram_ba_o,
  output logic [1:0]               sdram_dqm_o,
  output logic [15:0]              sdram_dout_o,
  output logic [15:0]              sdram_updout_o,
  output logic                     sdram_dout_en_o,
  input  wire [15:0]               sdram_din_i,
  input  wire [15:0]               sdram_updin_i
);

  localparam int DLY_W = $clog2(`SDRAM_INIT_CYCLES);
  localparam int REF_W = $clog2(`SDRAM_REFRESH_CYCLES);

  // Encoded as cs, ras, cas, we.
  localparam logic [3:0] CMD_DESEL     = 4'b1111;
  localparam logic [3:0] CMD_ACTIVE    = 4'b0011;
  localparam logic [3:0] CMD_READ      = 4'b0101;
  localparam logic [3:0] CMD_WRITE     = 4'b0100;
  localparam logic [3:0] CMD_PRECHARGE = 4'b0010;
  localparam logic [3:0] CMD_REFRESH   = 4'b0001;
  localparam logic [3:0] CMD_MODE      = 4'b0000;

  // Burst length 1, sequential.
  localparam sdram_a_t MODE_VALUE = sdram_a_t'(`SDRAM_CAS_LAT << 4);
  localparam sdram_a_t A10        = sdram_a_t'(11'h400);

  ctrl_state_t             state_q;
  logic [DLY_W-1:0]        dly_q;
  logic [REF_W-1:0]        ref_cnt_q;
  logic                    ref_pend_q;
  logic                    init_ref_q;
  logic                    pend_q;
  logic                    credit_q;
  logic                    dout_en_q;
  logic [3:0]              cmd_q;
  sdram_a_t                a_q;
  logic [`SDRAM_BANK_W-1:0] ba_q;
  logic                    entry_write_q;
  word_addr_t              entry_addr_q;
  data_t                   entry_wdata_q;
  strb_t                   entry_strb_q;
  data_t                   rdata_q;
  logic [`SDRAM_COL_W-1:0] col;
  sdram_a_t                row;
  logic [`SDRAM_BANK_W-1:0] bank;
  logic                    dly_done;

  assign col      = entry_addr_q[`SDRAM_COL_W-1:0];
  assign row      = entry_addr_q[`SDRAM_COL_W +: `SDRAM_ROW_W];
  assign bank     = entry_addr_q[`SDRAM_COL_W+`SDRAM_ROW_W +: `SDRAM_BANK_W];
  assign dly_done = (dly_q == '0);

  // ######################################
  // Command sequencer
  // ######################################

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= INIT_WAIT;
      dly_q      <= DLY_W'(`SDRAM_INIT_CYCLES - 1);
      ref_cnt_q  <= REF_W'(`SDRAM_REFRESH_CYCLES - 1);
      ref_pend_q <= 1'b0;
      init_ref_q <= 1'b0;
      pend_q     <= 1'b0;
      credit_q   <= 1'b0;
      dout_en_q  <= 1'b0;
      cmd_q      <= CMD_DESEL;
      a_q        <= '0;
      ba_q       <= '0;
    end else begin
      cmd_q     <= CMD_DESEL;
      dout_en_q <= 1'b0;
      credit_q  <= 1'b0;
      if (!dly_done) begin
        dly_q <= dly_q - 1'b1;
      end
      if (req.valid) begin
        pend_q <= 1'b1;
      end

      case (state_q)
        INIT_WAIT: begin
          if (dly_done) begin
            cmd_q   <= CMD_PRECHARGE;
            a_q     <= A10;
            dly_q   <= DLY_W'(`SDRAM_TRP - 1);
            state_q <= INIT_PRECHARGE;
          end
        end
        INIT_PRECHARGE: begin
          if (dly_done) begin
            cmd_q   <= CMD_REFRESH;
            dly_q   <= DLY_W'(`SDRAM_TRFC - 1);
            state_q <= INIT_REFRESH;
          end
        end
        INIT_REFRESH: begin
          // Two refreshes before the mode register.
          if (dly_done && !init_ref_q) begin
            cmd_q      <= CMD_REFRESH;
            dly_q      <= DLY_W'(`SDRAM_TRFC - 1);
            init_ref_q <= 1'b1;
          end else if (dly_done) begin
            cmd_q   <= CMD_MODE;
            a_q     <= MODE_VALUE;
            ba_q    <= '0;
            dly_q   <= DLY_W'(`SDRAM_TRP - 1);
            state_q <= INIT_MODE;
          end
        end
        INIT_MODE: begin
          if (dly_done) begin
            state_q <= IDLE;
          end
        end
        IDLE: begin
          if (ref_pend_q) begin
            cmd_q      <= CMD_REFRESH;
            ref_pend_q <= 1'b0;
            dly_q      <= DLY_W'(`SDRAM_TRFC - 1);
            state_q    <= REFRESH_WAIT;
          end else if (pend_q) begin
            pend_q  <= 1'b0;
            cmd_q   <= CMD_ACTIVE;
            a_q     <= row;
            ba_q    <= bank;
            dly_q   <= DLY_W'(`SDRAM_TRCD - 1);
            state_q <= ACTIVATE;
          end
        end
        ACTIVATE: begin
          if (dly_done) begin
            cmd_q     <= entry_write_q ? CMD_WRITE : CMD_READ;
            a_q       <= sdram_a_t'(col) | A10;
            dout_en_q <= entry_write_q;
            state_q   <= ACCESS;
          end
        end
        ACCESS: begin
          if (entry_write_q) begin
            dly_q   <= DLY_W'(`SDRAM_TRP - 1);
            state_q <= PRECHARGE_WAIT;
          end else begin
            dly_q   <= DLY_W'(`SDRAM_CAS_LAT - 1);
            state_q <= READ_WAIT;
          end
        end
        READ_WAIT: begin
          if (dly_done) begin
            dly_q   <= DLY_W'(`SDRAM_TRP - 1);
            state_q <= PRECHARGE_WAIT;
          end
        end
        PRECHARGE_WAIT: begin
          if (dly_done) begin
            credit_q <= 1'b1;
            state_q  <= IDLE;
          end
        end
        REFRESH_WAIT: begin
          if (dly_done) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= INIT_WAIT;
        end
      endcase

      // Refresh interval timer.
      if (ref_cnt_q == '0) begin
        ref_cnt_q  <= REF_W'(`SDRAM_REFRESH_CYCLES - 1);
        ref_pend_q <= 1'b1;
      end else begin
        ref_cnt_q <= ref_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req.valid) begin
      entry_write_q <= req.write;
      entry_addr_q  <= req.addr;
      entry_wdata_q <= req.wdata;
      entry_strb_q  <= req.strb;
    end
    if (state_q == READ_WAIT && dly_done) begin
      rdata_q <= {sdram_updin_i, sdram_din_i};
    end
  end

  // ######################################
  // Pins
  // ######################################

  // Inverted so the device samples mid-cycle.
  assign sdram_clk_o = ~clk_i;
  assign sdram_cke_o = 1'b1;
  assign {sdram_cs_o, sdram_ras_o, sdram_cas_o, sdram_we_o} = cmd_q;
  assign sdram_a_o   = a_q;
  assign sdram_ba_o  = ba_q;

  // dqm[k] covers byte k of both halves.
  assign sdram_dqm_o = entry_write_q ? ~(entry_strb_q[1:0] | entry_strb_q[3:2]) : 2'b00;

  assign sdram_dout_o    = entry_wdata_q[15:0];
  assign sdram_updout_o  = entry_wdata_q[31:16];
  assign sdram_dout_en_o = dout_en_q;

  assign req.credit = credit_q;
  assign req.rdata  = rdata_q;

endmodule

`default_nettype wire

// File: rtl/sdram_top_axi.sv
`timescale 1ns/1ns
`default_nettype none
`include "sdram_defines.svh"

module sdram_top_axi
  import sdram_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_n_i,

  input  wire                      in_awvalid_i,
  input  wire axi_addr_t           in_awaddr_i,
  input  wire axi_id_t             in_awid_i,
  output logic                     in_awready_o,
  input  wire                      in_wvalid_i,
  input  wire data_t               in_wdata_i,
  input  wire strb_t               in_wstrb_i,
  input  wire                      in_wlast_i,
  output logic                     in_wready_o,
  input  wire                      in_bready_i,
  output logic                     in_bvalid_o,
  output logic [1:0]               in_bresp_o,
  output axi_id_t                  in_bid_o,

  input  wire                      in_arvalid_i,
  input  wire axi_addr_t           in_araddr_i,
  input  wire axi_id_t             in_arid_i,
  output logic                     in_arready_o,
  input  wire                      in_rready_i,
  output logic                     in_rvalid_o,
  output logic [1:0]               in_rresp_o,
  output data_t                    in_rdata_o,
  output logic                     in_rlast_o,
  output axi_id_t                  in_rid_o,

  output logic                     sdram_clk_o,
  output logic                     sdram_cke_o,
  output logic                     sdram_cs_o,
  output logic                     sdram_ras_o,
  output logic                     sdram_cas_o,
  output logic                     sdram_we_o,
  output sdram_a_t                 sdram_a_o,
  output logic [`SDRAM_BANK_W-1:0] sdram_ba_o,
  output logic [1:0]               sdram_dqm_o,
  inout  wire [15:0]               sdram_dq_io,
  inout  wire [15:0]               sdram_updq_io
);

  logic        sdram_dout_en;
  logic [15:0] sdram_dout;
  logic [15:0] sdram_updout;

  mem_req_if wr_if ();
  mem_req_if rd_if ();
  mem_req_if mem_if ();

  // ######################################
  // AXI ports
  // ######################################

  // Writes are single beat. in_wlast_i is left unread.
  axi_write_port u_write_port (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .awvalid_i (in_awvalid_i),
    .awaddr_i  (in_awaddr_i),
    .awid_i    (in_awid_i),
    .awready_o (in_awready_o),
    .wvalid_i  (in_wvalid_i),
    .wdata_i   (in_wdata_i),
    .wstrb_i   (in_wstrb_i),
    .wready_o  (in_wready_o),
    .bready_i  (in_bready_i),
    .bvalid_o  (in_bvalid_o),
    .bresp_o   (in_bresp_o),
    .bid_o     (in_bid_o),
    .req       (wr_if.requester)
  );

  axi_read_port u_read_port (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .arvalid_i (in_arvalid_i),
    .araddr_i  (in_araddr_i),
    .arid_i    (in_arid_i),
    .arready_o (in_arready_o),
    .rready_i  (in_rready_i),
    .rvalid_o  (in_rvalid_o),
    .rresp_o   (in_rresp_o),
    .rdata_o   (in_rdata_o),
    .rlast_o   (in_rlast_o),
    .rid_o     (in_rid_o),
    .req       (rd_if.requester)
  );

  req_arbiter u_arbiter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wr_req  (wr_if.server),
    .rd_req  (rd_if.server),
    .mem     (mem_if.requester)
  );

  // ######################################
  // SDRAM side
  // ######################################

  sdram_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req             (mem_if.server),
    .sdram_clk_o     (sdram_clk_o),
    .sdram_cke_o     (sdram_cke_o),
    .sdram_cs_o      (sdram_cs_o),
    .sdram_ras_o     (sdram_ras_o),
    .sdram_cas_o     (sdram_cas_o),
    .sdram_we_o      (sdram_we_o),
    .sdram_a_o       (sdram_a_o),
    .sdram_ba_o      (sdram_ba_o),
    .sdram_dqm_o     (sdram_dqm_o),
    .sdram_dout_o    (sdram_dout),
    .sdram_updout_o  (sdram_updout),
    .sdram_dout_en_o (sdram_dout_en),
    .sdram_din_i     (sdram_dq_io),
    .sdram_updin_i   (sdram_updq_io)
  );

  assign sdram_dq_io   = sdram_dout_en ? sdram_dout : 16'bz;
  assign sdram_updq_io = sdram_dout_en ? sdram_updout : 16'bz;

endmodule

`default_nettype wire

// File: tb/sdram_model.sv
`timescale 1ns/1ns
`default_nettype none
`include "sdram_defines.svh"

module sdram_model (
  input  wire                     clk_i,
  input  wire                     cke_i,
  input  wire                     cs_i,
  input  wire                     ras_i,
  input  wire                     cas_i,
  input  wire                     we_i,
  input  wire [`SDRAM_ROW_W-1:0]  a_i,
  input  wire [`SDRAM_BANK_W-1:0] ba_i,
  input  wire [1:0]               dqm_i,
  inout  wire [15:0]              dq_io,
  inout  wire [15:0]              updq_io
);

  localparam int KEY_W = `SDRAM_BANK_W + `SDRAM_ROW_W + `SDRAM_COL_W;

  // Sparse storage, only written words exist.
  logic [31:0]               mem [logic [KEY_W-1:0]];
  logic [`SDRAM_ROW_W-1:0]   open_row [0:(1<<`SDRAM_BANK_W)-1];
  logic [31:0]               pipe_data [0:`SDRAM_CAS_LAT-1];
  logic [`SDRAM_CAS_LAT-1:0] pipe_en = '0;
  logic [31:0]               out_data = '0;
  logic                      out_en = 1'b0;
  logic [KEY_W-1:0]          key;
  logic [31:0]               bus_word;
  logic [31:0]               word;

  assign key      = {ba_i, open_row[ba_i], a_i[`SDRAM_COL_W-1:0]};
  assign bus_word = {updq_io, dq_io};

  always @(posedge clk_i) begin
    if (cke_i) begin
      // Read data leaves the pipe CAS latency edges after READ.
      out_en   <= pipe_en[`SDRAM_CAS_LAT-1];
      out_data <= pipe_data[`SDRAM_CAS_LAT-1];
      for (int i = `SDRAM_CAS_LAT - 1; i > 0; i--) begin
        pipe_en[i]   <= pipe_en[i-1];
        pipe_data[i] <= pipe_data[i-1];
      end
      pipe_en[0] <= 1'b0;
      case ({cs_i, ras_i, cas_i, we_i})
        4'b0011: begin
          open_row[ba_i] <= a_i;
        end
        4'b0101: begin
          pipe_en[0]   <= 1'b1;
          pipe_data[0] <= mem.exists(key) ? mem[key] : 32'h0;
        end
        4'b0100: begin
          word = mem.exists(key) ? mem[key] : 32'h0;
          // dqm[k] masks byte k of both halves.
          for (int b = 0; b < 4; b++) begin
            if (!dqm_i[b % 2]) begin
              word[8*b +: 8] = bus_word[8*b +: 8];
            end
          end
          mem[key] = word;
        end
        default: begin
        end
      endcase
    end
  end

  assign dq_io   = out_en ? out_data[15:0] : 16'bz;
  assign updq_io = out_en ? out_data[31:16] : 16'bz;

endmodule

`default_nettype wire

// File: tb/tb_sdram_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "sdram_defines.svh"

module tb_sdram_top
  import sdram_pkg::*;
();

  localparam int SEED    = 89487;
  localparam int TIMEOUT = 2 * `SDRAM_INIT_CYCLES;

  logic        clk;
  logic        rst_n;
  logic        in_awvalid;
  axi_addr_t   in_awaddr;
  axi_id_t     in_awid;
  logic        in_wvalid;
  data_t       in_wdata;
  strb_t       in_wstrb;
  logic        in_wlast;
  logic        in_bready;
  logic        in_arvalid;
  axi_addr_t   in_araddr;
  axi_id_t     in_arid;
  logic        in_rready;
  wire         in_awready;
  wire         in_wready;
  wire         in_bvalid;
  wire  [1:0]  in_bresp;
  wire  [3:0]  in_bid;
  wire         in_arready;
  wire         in_rvalid;
  wire  [1:0]  in_rresp;
  wire  [31:0] in_rdata;
  wire         in_rlast;
  wire  [3:0]  in_rid;
  wire         sdram_clk;
  wire         sdram_cke;
  wire         sdram_cs;
  wire         sdram_ras;
  wire         sdram_cas;
  wire         sdram_we;
  wire  [12:0] sdram_a;
  wire  [1:0]  sdram_ba;
  wire  [1:0]  sdram_dqm;
  wire  [15:0] sdram_dq;
  wire  [15:0] sdram_updq;

  int        errors;
  int        test_start_errors;
  int        tests_run;
  int        tests_failed;
  logic      timed_out;
  data_t     scoreboard [axi_addr_t];
  axi_addr_t written_addrs [$];

  always #2 clk = ~clk;

  sdram_top_axi i_dut (
    .clk_i (clk), .rst_n_i (rst_n),
    .in_awvalid_i (in_awvalid), .in_awaddr_i (in_awaddr), .in_awid_i (in_awid),
    .in_awready_o (in_awready), .in_wvalid_i (in_wvalid), .in_wdata_i (in_wdata),
    .in_wstrb_i (in_wstrb), .in_wlast_i (in_wlast), .in_wready_o (in_wready),
    .in_bready_i (in_bready), .in_bvalid_o (in_bvalid), .in_bresp_o (in_bresp),
    .in_bid_o (in_bid), .in_arvalid_i (in_arvalid), .in_araddr_i (in_araddr),
    .in_arid_i (in_arid), .in_arready_o (in_arready), .in_rready_i (in_rready),
    .in_rvalid_o (in_rvalid), .in_rresp_o (in_rresp), .in_rdata_o (in_rdata),
    .in_rlast_o (in_rlast), .in_rid_o (in_rid),
    .sdram_clk_o (sdram_clk), .sdram_cke_o (sdram_cke), .sdram_cs_o (sdram_cs),
    .sdram_ras_o (sdram_ras), .sdram_cas_o (sdram_cas), .sdram_we_o (sdram_we),
    .sdram_a_o (sdram_a), .sdram_ba_o (sdram_ba), .sdram_dqm_o (sdram_dqm),
    .sdram_dq_io (sdram_dq), .sdram_updq_io (sdram_updq)
  );

  sdram_model i_sdram (
    .clk_i (sdram_clk), .cke_i (sdram_cke), .cs_i (sdram_cs), .ras_i (sdram_ras),
    .cas_i (sdram_cas), .we_i (sdram_we), .a_i (sdram_a), .ba_i (sdram_ba),
    .dqm_i (sdram_dqm), .dq_io (sdram_dq), .updq_io (sdram_updq)
  );

  // ######################################
  // Checking and bookkeeping
  // ######################################

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s is 0x%08h, expected 0x%08h at %0t ns",
               name, actual, expected, $time);
      errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout while waiting for %s at %0t ns", what, $time);
    timed_out = 1'b1;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_start_errors && !timed_out) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d check errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
    timed_out         = 1'b0;
  endtask

  // Strobe pair k writes byte k of both 16-bit halves.
  function automatic data_t merge_pairs(input data_t old_word, input data_t new_word,
                                        input strb_t strb);
    data_t      result;
    logic [1:0] lane;
    result = old_word;
    lane   = strb[1:0] | strb[3:2];
    for (int b = 0; b < 4; b++) begin
      if (lane[b % 2]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  // ######################################
  // AXI helpers
  // ######################################

  task automatic axi_write(input axi_addr_t addr, input axi_id_t id, input data_t data,
                           input strb_t strb, input int stall);
    int cycles;
    cycles = 0;
    @(negedge clk);
    in_awvalid = 1'b1;
    in_awaddr  = addr;
    in_awid    = id;
    in_wvalid  = 1'b1;
    in_wdata   = data;
    in_wstrb   = strb;
    #1;
    while (!(in_awready && in_wready) && cycles < TIMEOUT) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (!(in_awready && in_wready)) begin
      note_timeout("in_awready and in_wready");
    end
    @(negedge clk);
    in_awvalid = 1'b0;
    in_wvalid  = 1'b0;
    cycles     = 0;
    while (!in_bvalid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!in_bvalid) begin
      note_timeout("in_bvalid");
      return;
    end
    check_value("in_bresp", 32'(in_bresp), 32'd0);
    check_value("in_bid", 32'(in_bid), 32'(id));
    // A second write is offered while B is held back.
    repeat (stall) begin
      in_awvalid = 1'b1;
      in_wvalid  = 1'b1;
      #1;
      check_value("in_awready", 32'(in_awready), 32'd0);
      check_value("in_wready", 32'(in_wready), 32'd0);
      @(negedge clk);
      check_value("in_bvalid", 32'(in_bvalid), 32'd1);
      check_value("in_bid", 32'(in_bid), 32'(id));
    end
    in_awvalid = 1'b0;
    in_wvalid  = 1'b0;
    in_bready  = 1'b1;
    @(negedge clk);
    in_bready = 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, input axi_id_t id, input int stall,
                          output data_t data);
    int cycles;
    cycles = 0;
    data   = '0;
    @(negedge clk);
    in_arvalid = 1'b1;
    in_araddr  = addr;
    in_arid    = id;
    #1;
    while (!in_arready && cycles < TIMEOUT) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (!in_arready) begin
      note_timeout("in_arready");
    end
    @(negedge clk);
    in_arvalid = 1'b0;
    cycles     = 0;
    while (!in_rvalid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!in_rvalid) begin
      note_timeout("in_rvalid");
      return;
    end
    check_value("in_rresp", 32'(in_rresp), 32'd0);
    check_value("in_rlast", 32'(in_rlast), 32'd1);
    check_value("in_rid", 32'(in_rid), 32'(id));
    data = in_rdata;
    repeat (stall) begin
      @(negedge clk);
      check_value("in_rvalid", 32'(in_rvalid), 32'd1);
      check_value("in_rdata", in_rdata, data);
      check_value("in_rid", 32'(in_rid), 32'(id));
    end
    in_rready = 1'b1;
    @(negedge clk);
    in_rready = 1'b0;
  endtask

  // ######################################
  // Tests
  // ######################################

  task automatic write_then_read();
    data_t rd;
    axi_write(32'h0000_1230, 4'h3, 32'hCAFE_F00D, 4'hF, 0);
    axi_read(32'h0000_1230, 4'h5, 0, rd);
    check_value("in_rdata", rd, 32'hCAFE_F00D);
    end_test("write_read");
  endtask

  task automatic strobe_pair_masking();
    data_t rd;
    axi_write(32'h0100_8004, 4'h1, 32'hFFFF_FFFF, 4'hF, 0);
    axi_write(32'h0100_8004, 4'h2, 32'h0000_0000, 4'b0001, 0);
    axi_read(32'h0100_8004, 4'h4, 0, rd);
    // Bytes 0 and 2 share a mask pin.
    check_value("in_rdata", rd, 32'hFF00_FF00);
    end_test("strobe_pairs");
  endtask

  task automatic response_stall();
    data_t rd;
    int    wr_stall;
    int    rd_stall;
    wr_stall = int'($urandom_range(12, 3));
    rd_stall = int'($urandom_range(12, 3));
    axi_write(32'h0280_0FFC, 4'h6, 32'h1357_9BDF, 4'hF, wr_stall);
    axi_read(32'h0280_0FFC, 4'h7, rd_stall, rd);
    check_value("in_rdata", rd, 32'h1357_9BDF);
    end_test("back_pressure");
  endtask

  task automatic concurrent_ports();
    data_t rd;
    fork
      axi_write(32'h0300_0040, 4'h8, 32'h2468_ACE0, 4'hF, 0);
      axi_read(32'h0000_1230, 4'h9, 0, rd);
    join
    check_value("in_rdata", rd, 32'hCAFE_F00D);
    axi_read(32'h0300_0040, 4'hA, 0, rd);
    check_value("in_rdata", rd, 32'h2468_ACE0);
    end_test("concurrent_ports");
  endtask

  task automatic random_traffic();
    axi_addr_t addr;
    data_t     data;
    data_t     rd;
    strb_t     strb;
    for (int op = 0; op < 40; op++) begin
      // Idle gaps stretch the run over several refresh intervals.
      repeat ($urandom_range(100, 0)) @(negedge clk);
      if (written_addrs.size() == 0 || $urandom_range(1, 0) == 1) begin
        if (written_addrs.size() != 0 && $urandom_range(1, 0) == 1) begin
          addr = written_addrs[$urandom_range(written_addrs.size() - 1, 0)];
          strb = strb_t'($urandom_range(15, 1));
        end else begin
          addr = {6'b0, 2'($urandom), 13'($urandom), 9'($urandom), 2'b00};
          strb = 4'hF;
        end
        data = $urandom;
        axi_write(addr, axi_id_t'($urandom), data, strb, 0);
        if (scoreboard.exists(addr)) begin
          scoreboard[addr] = merge_pairs(scoreboard[addr], data, strb);
        end else begin
          scoreboard[addr] = data;
          written_addrs.push_back(addr);
        end
      end else begin
        addr = written_addrs[$urandom_range(written_addrs.size() - 1, 0)];
        axi_read(addr, axi_id_t'($urandom), 0, rd);
        check_value("in_rdata", rd, scoreboard[addr]);
      end
    end
    end_test("random_traffic");
  endtask

  initial begin
    void'($urandom(SEED));
    clk               = 1'b0;
    rst_n             = 1'b0;
    in_awvalid        = 1'b0;
    in_awaddr         = '0;
    in_awid           = '0;
    in_wvalid         = 1'b0;
    in_wdata          = '0;
    in_wstrb          = '0;
    in_wlast          = 1'b1;
    in_bready         = 1'b0;
    in_arvalid        = 1'b0;
    in_araddr         = '0;
    in_arid           = '0;
    in_rready         = 1'b0;
    errors            = 0;
    test_start_errors = 0;
    tests_run         = 0;
    tests_failed      = 0;
    timed_out         = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    write_then_read();
    strobe_pair_masking();
    response_stall();
    concurrent_ports();
    random_traffic();

    $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
rtl/sdram_pkg.sv
rtl/mem_req_if.sv
rtl/axi_write_port.sv
rtl/axi_read_port.sv
rtl/req_arbiter.sv
rtl/sdram_ctrl.sv
rtl/sdram_top_axi.sv
tb/sdram_model.sv
tb/tb_sdram_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the SDRAM AXI testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_sdram_top
LOG=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module "$TOP" -o "$TOP" --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  exit 0
fi
echo "Simulation did not report success, see $LOG"
exit 1
